//--- run.sh
#!/usr/bin/env bash
# Build and run the L1 data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f tb.f --top-module tb_l1d -o tb_l1d_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/tb_l1d_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "test failed" "$LOG"; then
    exit 1
fi

exit 0

//--- source/l1d_config.svh
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Core and bus widths
`define L1D_ADDR_BITS       32
`define L1D_WORD_BITS       32
`define L1D_BLOCK_BITS      128

// Cache organisation
`define L1D_WAYS            4
`define L1D_SETS            16

// Address split: tag | set index | byte offset within block
`define L1D_OFFSET_BITS     $clog2(`L1D_BLOCK_BITS / 8)
`define L1D_INDEX_BITS      $clog2(`L1D_SETS)
`define L1D_TAG_BITS        (`L1D_ADDR_BITS - `L1D_INDEX_BITS - `L1D_OFFSET_BITS)
`define L1D_WAY_BITS        $clog2(`L1D_WAYS)

// Word select inside a block
`define L1D_WORD_SEL_BITS   $clog2(`L1D_BLOCK_BITS / `L1D_WORD_BITS)

`endif

//--- source/l1d_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1d_config.svh"

module l1d_ctrl (
    input  wire                                   clk_i,
    input  wire                                   rstn_i,
    input  wire                                   core_req_valid_i,
    input  wire l1d_pkg::core_req_t               core_req_i,
    output logic                                  core_req_ready_o,
    output logic                                  core_rsp_valid_o,
    output l1d_pkg::word_t                        core_rsp_data_o,
    input  wire                                   core_rsp_ready_i,
    output logic                                  mem_req_valid_o,
    output l1d_pkg::mem_req_t                     mem_req_o,
    input  wire                                   mem_req_ready_i,
    input  wire                                   mem_rsp_valid_i,
    input  wire l1d_pkg::block_t                  mem_rsp_data_i,
    output logic                                  mem_rsp_ready_o,
    output l1d_pkg::set_idx_t                     set_o,
    output l1d_pkg::tag_t                         req_tag_o,
    input  wire l1d_pkg::tag_t   [`L1D_WAYS-1:0]  tags_i,
    input  wire l1d_pkg::block_t [`L1D_WAYS-1:0]  blocks_i,
    input  wire                                   hit_i,
    input  wire l1d_pkg::way_idx_t                hit_way_i,
    input  wire l1d_pkg::way_idx_t                victim_way_i,
    input  wire                                   victim_dirty_i,
    output logic                                  victim_advance_o,
    output logic                                  wr_en_o,
    output l1d_pkg::set_idx_t                     wr_set_o,
    output l1d_pkg::way_idx_t                     wr_way_o,
    output l1d_pkg::tag_t                         wr_tag_o,
    output l1d_pkg::block_t                       wr_block_o,
    output logic                                  wr_valid_o,
    output logic                                  wr_dirty_o
);

    import l1d_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    core_req_t   req_q;
    mem_req_t    mem_req_q;
    mem_req_t    fill_req;
    way_idx_t    victim_q;
    word_t       rsp_data_q;
    block_t      merged_block;
    tag_t        req_tag;
    set_idx_t    req_set;
    logic        req_fire;
    logic        mem_req_fire;
    logic        mem_rsp_fire;
    logic        rsp_fire;

    assign req_tag   = addr_tag(req_q.addr);
    assign req_set   = addr_set(req_q.addr);
    assign set_o     = req_set;
    assign req_tag_o = req_tag;

    assign core_req_ready_o = (state_q == IDLE);
    assign core_rsp_valid_o = (state_q == RESPOND);
    assign core_rsp_data_o  = rsp_data_q;
    assign mem_req_valid_o  = (state_q == WRITEBACK) || (state_q == FILL_REQ);
    assign mem_req_o        = mem_req_q;
    assign mem_rsp_ready_o  = (state_q == FILL_WAIT);

    assign req_fire     = core_req_valid_i && core_req_ready_o;
    assign rsp_fire     = core_rsp_valid_o && core_rsp_ready_i;
    assign mem_req_fire = mem_req_valid_o && mem_req_ready_i;
    assign mem_rsp_fire = mem_rsp_valid_i && mem_rsp_ready_o;

    assign victim_advance_o = mem_rsp_fire;
    assign fill_req = '{addr: block_addr(req_tag, req_set), write: 1'b0, wdata: '0};

    always_comb begin
        merged_block = blocks_i[hit_way_i];
        merged_block[addr_word(req_q.addr) * `L1D_WORD_BITS +: `L1D_WORD_BITS] = req_q.wdata;
    end

    // Write hits dirty the hit way, fills install the victim way clean
    always_comb begin
        wr_en_o    = 1'b0;
        wr_way_o   = hit_way_i;
        wr_block_o = merged_block;
        wr_dirty_o = 1'b1;
        if (state_q == LOOKUP && hit_i && req_q.write) begin
            wr_en_o = 1'b1;
        end else if (mem_rsp_fire) begin
            wr_en_o    = 1'b1;
            wr_way_o   = victim_q;
            wr_block_o = mem_rsp_data_i;
            wr_dirty_o = 1'b0;
        end
    end

    assign wr_set_o   = req_set;
    assign wr_tag_o   = req_tag;
    assign wr_valid_o = 1'b1;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:      if (req_fire) state_d = LOOKUP;
            LOOKUP: begin
                if (hit_i) begin
                    state_d = req_q.write ? IDLE : RESPOND;
                end else begin
                    state_d = victim_dirty_i ? WRITEBACK : FILL_REQ;
                end
            end
            WRITEBACK: if (mem_req_fire) state_d = FILL_REQ;
            FILL_REQ:  if (mem_req_fire) state_d = FILL_WAIT;
            FILL_WAIT: if (mem_rsp_fire) state_d = LOOKUP;
            RESPOND:   if (rsp_fire) state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            req_q <= core_req_i;
        end
        if (state_q == LOOKUP) begin
            if (hit_i) begin
                rsp_data_q <= blocks_i[hit_way_i][addr_word(req_q.addr) * `L1D_WORD_BITS
                                                  +: `L1D_WORD_BITS];
            end else begin
                victim_q <= victim_way_i;
                // Dirty victim goes out first, the fill follows
                if (victim_dirty_i) begin
                    mem_req_q <= '{addr:  block_addr(tags_i[victim_way_i], req_set),
                                   write: 1'b1,
                                   wdata: blocks_i[victim_way_i]};
                end else begin
                    mem_req_q <= fill_req;
                end
            end
        end
        if (state_q == WRITEBACK && mem_req_fire) begin
            mem_req_q <= fill_req;
        end
    end

    a_mem_req_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o));

    a_core_rsp_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        core_rsp_valid_o && !core_rsp_ready_i |=> core_rsp_valid_o && $stable(core_rsp_data_o));

endmodule

`default_nettype wire

//--- source/l1d_pkg.sv
`default_nettype none

`include "l1d_config.svh"

package l1d_pkg;

    typedef logic [`L1D_ADDR_BITS-1:0]  addr_t;
    typedef logic [`L1D_WORD_BITS-1:0]  word_t;
    typedef logic [`L1D_BLOCK_BITS-1:0] block_t;
    typedef logic [`L1D_TAG_BITS-1:0]   tag_t;
    typedef logic [`L1D_INDEX_BITS-1:0] set_idx_t;
    typedef logic [`L1D_WAY_BITS-1:0]   way_idx_t;
    typedef logic [`L1D_WAYS-1:0]       way_mask_t;

    typedef struct packed {
        addr_t addr;
        logic  write;
        word_t wdata;
    } core_req_t;

    // Bus addresses are always block aligned
    typedef struct packed {
        addr_t  addr;
        logic   write;
        block_t wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL_REQ,
        FILL_WAIT,
        RESPOND
    } ctrl_state_e;

    function automatic tag_t addr_tag(addr_t a);
        return a[`L1D_ADDR_BITS-1 -: `L1D_TAG_BITS];
    endfunction

    function automatic set_idx_t addr_set(addr_t a);
        return a[`L1D_OFFSET_BITS +: `L1D_INDEX_BITS];
    endfunction

    function automatic logic [`L1D_WORD_SEL_BITS-1:0] addr_word(addr_t a);
        return a[`L1D_OFFSET_BITS-1 -: `L1D_WORD_SEL_BITS];
    endfunction

    function automatic addr_t block_addr(tag_t tag, set_idx_t set);
        return {tag, set, {`L1D_OFFSET_BITS{1'b0}}};
    endfunction

endpackage

`default_nettype wire

//--- source/l1d_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1d_config.svh"

module l1d_top (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         core_req_valid_i,
    input  wire l1d_pkg::core_req_t     core_req_i,
    output logic                        core_req_ready_o,
    output logic                        core_rsp_valid_o,
    output l1d_pkg::word_t              core_rsp_data_o,
    input  wire                         core_rsp_ready_i,
    output logic                        mem_req_valid_o,
    output l1d_pkg::mem_req_t           mem_req_o,
    input  wire                         mem_req_ready_i,
    input  wire                         mem_rsp_valid_i,
    input  wire l1d_pkg::block_t        mem_rsp_data_i,
    output logic                        mem_rsp_ready_o
);

    import l1d_pkg::*;

    set_idx_t               set;
    tag_t                   req_tag;
    tag_t   [`L1D_WAYS-1:0] tags;
    block_t [`L1D_WAYS-1:0] blocks;
    way_mask_t              valid_mask;
    way_mask_t              dirty_mask;
    logic                   hit;
    way_idx_t               hit_way;
    way_idx_t               victim_way;
    logic                   victim_dirty;
    logic                   victim_advance;
    logic                   wr_en;
    set_idx_t               wr_set;
    way_idx_t               wr_way;
    tag_t                   wr_tag;
    block_t                 wr_block;
    logic                   wr_valid;
    logic                   wr_dirty;

    l1d_ctrl u_ctrl (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .core_req_valid_i (core_req_valid_i),
        .core_req_i       (core_req_i),
        .core_req_ready_o (core_req_ready_o),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_data_o  (core_rsp_data_o),
        .core_rsp_ready_i (core_rsp_ready_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_req_ready_i  (mem_req_ready_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_data_i   (mem_rsp_data_i),
        .mem_rsp_ready_o  (mem_rsp_ready_o),
        .set_o            (set),
        .req_tag_o        (req_tag),
        .tags_i           (tags),
        .blocks_i         (blocks),
        .hit_i            (hit),
        .hit_way_i        (hit_way),
        .victim_way_i     (victim_way),
        .victim_dirty_i   (victim_dirty),
        .victim_advance_o (victim_advance),
        .wr_en_o          (wr_en),
        .wr_set_o         (wr_set),
        .wr_way_o         (wr_way),
        .wr_tag_o         (wr_tag),
        .wr_block_o       (wr_block),
        .wr_valid_o       (wr_valid),
        .wr_dirty_o       (wr_dirty)
    );

    l1d_way_store u_store (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .rd_set_i    (set),
        .rd_tags_o   (tags),
        .rd_blocks_o (blocks),
        .rd_valid_o  (valid_mask),
        .rd_dirty_o  (dirty_mask),
        .wr_en_i     (wr_en),
        .wr_set_i    (wr_set),
        .wr_way_i    (wr_way),
        .wr_tag_i    (wr_tag),
        .wr_block_i  (wr_block),
        .wr_valid_i  (wr_valid),
        .wr_dirty_i  (wr_dirty)
    );

    l1d_victim_select u_victim (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .req_tag_i      (req_tag),
        .tags_i         (tags),
        .valid_i        (valid_mask),
        .dirty_i        (dirty_mask),
        .advance_i      (victim_advance),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

endmodule

`default_nettype wire

//--- source/l1d_victim_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1d_config.svh"

module l1d_victim_select (
    input  wire                                 clk_i,
    input  wire                                 rstn_i,
    input  wire l1d_pkg::tag_t                  req_tag_i,
    input  wire l1d_pkg::tag_t [`L1D_WAYS-1:0]  tags_i,
    input  wire l1d_pkg::way_mask_t             valid_i,
    input  wire l1d_pkg::way_mask_t             dirty_i,
    input  wire                                 advance_i,
    output logic                                hit_o,
    output l1d_pkg::way_idx_t                   hit_way_o,
    output l1d_pkg::way_idx_t                   victim_way_o,
    output logic                                victim_dirty_o
);

    import l1d_pkg::*;

    way_mask_t hit_vec;
    way_idx_t  rr_ptr_q;
    way_idx_t  free_way;
    logic      has_free;

    always_comb begin
        hit_way_o = '0;
        free_way  = '0;
        has_free  = 1'b0;
        for (int w = 0; w < `L1D_WAYS; w++) begin
            hit_vec[w] = valid_i[w] && (tags_i[w] == req_tag_i);
            if (hit_vec[w]) begin
                hit_way_o = way_idx_t'(w);
            end
        end
        // Walk down so the lowest invalid way wins
        for (int w = `L1D_WAYS - 1; w >= 0; w--) begin
            if (!valid_i[w]) begin
                free_way = way_idx_t'(w);
                has_free = 1'b1;
            end
        end
    end

    assign hit_o          = |hit_vec;
    assign victim_way_o   = has_free ? free_way : rr_ptr_q;
    assign victim_dirty_o = valid_i[victim_way_o] && dirty_i[victim_way_o];

    // Pointer only moves when a fill is installed
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rr_ptr_q <= '0;
        end else if (advance_i) begin
            rr_ptr_q <= rr_ptr_q + 1'b1;
        end
    end

    a_single_hit: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- source/l1d_way_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1d_config.svh"

module l1d_way_store (
    input  wire                                   clk_i,
    input  wire                                   rstn_i,
    input  wire l1d_pkg::set_idx_t                rd_set_i,
    output l1d_pkg::tag_t   [`L1D_WAYS-1:0]       rd_tags_o,
    output l1d_pkg::block_t [`L1D_WAYS-1:0]       rd_blocks_o,
    output l1d_pkg::way_mask_t                    rd_valid_o,
    output l1d_pkg::way_mask_t                    rd_dirty_o,
    input  wire                                   wr_en_i,
    input  wire l1d_pkg::set_idx_t                wr_set_i,
    input  wire l1d_pkg::way_idx_t                wr_way_i,
    input  wire l1d_pkg::tag_t                    wr_tag_i,
    input  wire l1d_pkg::block_t                  wr_block_i,
    input  wire                                   wr_valid_i,
    input  wire                                   wr_dirty_i
);

    import l1d_pkg::*;

    tag_t   [`L1D_WAYS-1:0] tag_mem   [`L1D_SETS];
    block_t [`L1D_WAYS-1:0] block_mem [`L1D_SETS];
    way_mask_t              valid_q   [`L1D_SETS];
    way_mask_t              dirty_q   [`L1D_SETS];

    // All ways of the addressed set in the same cycle
    assign rd_tags_o   = tag_mem[rd_set_i];
    assign rd_blocks_o = block_mem[rd_set_i];
    assign rd_valid_o  = valid_q[rd_set_i];
    assign rd_dirty_o  = dirty_q[rd_set_i];

    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            tag_mem[wr_set_i][wr_way_i]   <= wr_tag_i;
            block_mem[wr_set_i][wr_way_i] <= wr_block_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int s = 0; s < `L1D_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (wr_en_i) begin
            valid_q[wr_set_i][wr_way_i] <= wr_valid_i;
            dirty_q[wr_set_i][wr_way_i] <= wr_dirty_i;
        end
    end

    // A dirty way must hold a valid block
    a_dirty_implies_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_en_i && wr_dirty_i |-> wr_valid_i);

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/l1d_pkg.sv
source/l1d_way_store.sv
source/l1d_victim_select.sv
source/l1d_ctrl.sv
source/l1d_top.sv
tests/tb_l1d_mem.sv
tests/tb_l1d.sv

//--- tests/tb_l1d.sv
`timescale 1ns/100ps
`default_nettype none

module tb_l1d;

    import l1d_pkg::*;

    localparam int unsigned SEED = 32'h78fe169f;
    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 4;
    localparam int DIRECTED_REQS  = 17;
    localparam int RANDOM_OPS     = 200;
    localparam int CYCLES_PER_REQ = 200;

    localparam addr_t    COLD_ADDR    = 32'h0000_1044;
    localparam addr_t    NEIGHBOR_BASE = 32'h0000_2080;
    localparam set_idx_t CONFLICT_SET = 4'd5;

    logic      clk;
    logic      rstn;
    logic      core_req_valid;
    core_req_t core_req;
    logic      core_req_ready;
    logic      core_rsp_valid;
    word_t     core_rsp_data;
    logic      core_rsp_ready;
    logic      mem_req_valid;
    mem_req_t  mem_req;
    logic      mem_req_ready;
    logic      mem_rsp_valid;
    block_t    mem_rsp_data;
    logic      mem_rsp_ready;

    word_t     shadow [addr_t];
    int        data_errors;
    int        flag_errors;

    l1d_top u_l1d_top (
        .clk_i            (clk),
        .rstn_i           (rstn),
        .core_req_valid_i (core_req_valid),
        .core_req_i       (core_req),
        .core_req_ready_o (core_req_ready),
        .core_rsp_valid_o (core_rsp_valid),
        .core_rsp_data_o  (core_rsp_data),
        .core_rsp_ready_i (core_rsp_ready),
        .mem_req_valid_o  (mem_req_valid),
        .mem_req_o        (mem_req),
        .mem_req_ready_i  (mem_req_ready),
        .mem_rsp_valid_i  (mem_rsp_valid),
        .mem_rsp_data_i   (mem_rsp_data),
        .mem_rsp_ready_o  (mem_rsp_ready)
    );

    tb_l1d_mem u_mem (
        .clk_i           (clk),
        .rstn_i          (rstn),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_i       (mem_req),
        .mem_req_ready_o (mem_req_ready),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_data_o  (mem_rsp_data),
        .mem_rsp_ready_i (mem_rsp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Same address pattern as the memory model uses for untouched words
    function automatic word_t expected_word(addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {a[31:16] ^ 16'hc3a5, a[15:0]};
    endfunction

    task automatic check_word(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            data_errors++;
        end
    endtask

    task automatic check_flag(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            flag_errors++;
        end
    endtask

    task automatic issue_request(addr_t addr, logic write, word_t wdata);
        logic accepted;
        @(posedge clk);
        #1;
        core_req_valid = 1'b1;
        core_req       = '{addr: addr, write: write, wdata: wdata};
        do begin
            @(negedge clk);
            accepted = core_req_ready;
            @(posedge clk);
        end while (!accepted);
        #1;
        core_req_valid = 1'b0;
    endtask

    task automatic write_word(addr_t addr, word_t data);
        issue_request(addr, 1'b1, data);
        shadow[addr] = data;
    endtask

    task automatic read_check(addr_t addr);
        issue_request(addr, 1'b0, '0);
        do begin
            @(negedge clk);
        end while (!core_rsp_valid);
        check_word($sformatf("core_rsp_data_o[%h]", addr), core_rsp_data, expected_word(addr));
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        check_flag("core_req_ready_o", core_req_ready, 1'b1);
        check_flag("core_rsp_valid_o", core_rsp_valid, 1'b0);
        check_flag("mem_req_valid_o", mem_req_valid, 1'b0);
        check_flag("mem_rsp_ready_o", mem_rsp_ready, 1'b0);
    endtask

    task automatic test_write_then_read();
        write_word(NEIGHBOR_BASE + 32'h4, 32'h1234_5678);
        for (int w = 0; w < 4; w++) begin
            read_check(NEIGHBOR_BASE + addr_t'(4 * ((w + 1) % 4)));
        end
    endtask

    task automatic test_set_conflict();
        for (int t = 1; t <= 5; t++) begin
            write_word({tag_t'(t), CONFLICT_SET, 4'h8}, 32'hc0de_0000 + word_t'(t));
        end
        for (int t = 1; t <= 5; t++) begin
            read_check({tag_t'(t), CONFLICT_SET, 4'h8});
        end
    endtask

    task automatic test_rsp_backpressure();
        addr_t addr;
        word_t first;
        addr = NEIGHBOR_BASE + 32'h4;
        core_rsp_ready = 1'b0;
        issue_request(addr, 1'b0, '0);
        do begin
            @(negedge clk);
        end while (!core_rsp_valid);
        first = core_rsp_data;
        check_word("core_rsp_data_o", first, expected_word(addr));
        repeat (5) begin
            @(negedge clk);
            check_flag("core_rsp_valid_o", core_rsp_valid, 1'b1);
            check_word("core_rsp_data_o", core_rsp_data, first);
            check_flag("core_req_ready_o", core_req_ready, 1'b0);
        end
        @(posedge clk);
        #1;
        core_rsp_ready = 1'b1;
        @(negedge clk);
        check_flag("core_rsp_valid_o", core_rsp_valid, 1'b1);
        @(negedge clk);
        // One cycle after the handshake the cache is idle again
        check_flag("core_rsp_valid_o", core_rsp_valid, 1'b0);
        check_flag("core_req_ready_o", core_req_ready, 1'b1);
        @(posedge clk);
        #1;
    endtask

    task automatic test_random_mix();
        addr_t addr;
        logic  is_write;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            addr = {tag_t'(24'h000a00 + $urandom_range(5, 0)),
                    set_idx_t'(10 + $urandom_range(2, 0)),
                    2'($urandom_range(3, 0)), 2'b00};
            is_write = 1'($urandom_range(1, 0));
            if (is_write) begin
                write_word(addr, $urandom());
            end else begin
                read_check(addr);
            end
        end
    endtask

    initial begin : watchdog
        repeat (RESET_CYCLES + (DIRECTED_REQS + RANDOM_OPS) * CYCLES_PER_REQ) @(posedge clk);
        $display("Timeout: the cache stopped answering before all tests finished");
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        data_errors    = 0;
        flag_errors    = 0;
        rstn           = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        core_rsp_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;

        test_reset_state();
        read_check(COLD_ADDR);
        test_write_then_read();
        test_set_conflict();
        test_rsp_backpressure();
        test_random_mix();

        $display("Checks done: %0d data errors, %0d flag errors", data_errors, flag_errors);
        if (data_errors + flag_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/tb_l1d_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "l1d_config.svh"

module tb_l1d_mem (
    input  wire                         clk_i,
    input  wire                         rstn_i,
    input  wire                         mem_req_valid_i,
    input  wire l1d_pkg::mem_req_t      mem_req_i,
    output logic                        mem_req_ready_o,
    output logic                        mem_rsp_valid_o,
    output l1d_pkg::block_t             mem_rsp_data_o,
    input  wire                         mem_rsp_ready_i
);

    import l1d_pkg::*;

    localparam int WORDS = `L1D_BLOCK_BITS / `L1D_WORD_BITS;

    // Sparse store of the blocks that were written back
    block_t   mem_q [addr_t];
    mem_req_t req_q;
    logic     rsp_taken;

    // Untouched words read as a pattern of their byte address
    function automatic word_t fill_word(addr_t a);
        return {a[31:16] ^ 16'hc3a5, a[15:0]};
    endfunction

    function automatic block_t read_block(addr_t base);
        block_t blk;
        if (mem_q.exists(base)) begin
            return mem_q[base];
        end
        for (int w = 0; w < WORDS; w++) begin
            blk[w*`L1D_WORD_BITS +: `L1D_WORD_BITS] = fill_word(base + addr_t'(4 * w));
        end
        return blk;
    endfunction

    initial begin
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_data_o  = '0;
        forever begin
            @(negedge clk_i);
            if (rstn_i && mem_req_valid_i) begin
                repeat ($urandom_range(3, 0)) @(posedge clk_i);
                #1 mem_req_ready_o = 1'b1;
                req_q = mem_req_i;
                @(posedge clk_i);
                #1 mem_req_ready_o = 1'b0;
                if (req_q.write) begin
                    mem_q[req_q.addr] = req_q.wdata;
                end else begin
                    repeat ($urandom_range(3, 0)) begin
                        @(posedge clk_i);
                        #1;
                    end
                    mem_rsp_valid_o = 1'b1;
                    mem_rsp_data_o = read_block(req_q.addr);
                    do begin
                        @(negedge clk_i);
                        rsp_taken = mem_rsp_ready_i;
                        @(posedge clk_i);
                    end while (!rsp_taken);
                    #1 mem_rsp_valid_o = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire
